// ==== filelist.f ====
logic/wn_mem_pkg.sv
logic/sram_bank.sv
logic/mem_arbiter.sv
logic/bank_port_mux.sv
logic/wide_narrow_mem_top.sv
bench/tb_clk_gen.sv
bench/tb_wide_narrow_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the scratchpad testbench with Verilator, run it and check the log
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_wide_narrow_mem \
    -Mdir "${build_dir}" \
    -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./${build_dir}/Vtb_wide_narrow_mem" > "${log_file}" 2>&1
sim_status=$?
cat "${log_file}"
if [ ${sim_status} -ne 0 ]; then
    echo "Simulation exited with status ${sim_status}"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "${log_file}"; then
    exit 0
fi
echo "Pass message not found in ${log_file}"
exit 1

// ==== bench/tb_wide_narrow_mem.sv ====
// Testbench for the banked scratchpad, directed and random traffic checked against a byte model
`timescale 1ns/1ps

module tb_wide_narrow_mem
    import wn_mem_pkg::*;
();

    localparam int unsigned WaitLimit    = 16;
    localparam int unsigned RandomCycles = 3000;

    logic clk;
    logic rst_n;

    logic [NumNarrowBanks-1:0]                      narrow_valid;
    logic [NumNarrowBanks-1:0]                      narrow_we;
    logic [NumNarrowBanks-1:0][BankAddrWidth-1:0]   narrow_addr;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0] narrow_wdata;
    logic [NumNarrowBanks-1:0][NarrowStrbWidth-1:0] narrow_strb;
    logic [NumNarrowBanks-1:0]                      narrow_ready;
    logic [NumNarrowBanks-1:0]                      narrow_rvalid;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0] narrow_rdata;
    logic [NumWideBanks-1:0]                        wide_valid;
    logic [NumWideBanks-1:0]                        wide_we;
    logic [NumWideBanks-1:0][BankAddrWidth-1:0]     wide_addr;
    logic [NumWideBanks-1:0][WideDataWidth-1:0]     wide_wdata;
    logic [NumWideBanks-1:0][WideStrbWidth-1:0]     wide_strb;
    logic [NumWideBanks-1:0]                        wide_ready;
    logic [NumWideBanks-1:0]                        wide_rvalid;
    logic [NumWideBanks-1:0][WideDataWidth-1:0]     wide_rdata;

    // Byte-level copy of all banks and the predicted responses
    logic [7:0]                                     ref_mem [NumNarrowBanks][BankDepth][4];
    logic [31:0]                                    cycle_cnt;
    logic [NumNarrowBanks-1:0]                      exp_narrow_ready;
    logic [NumNarrowBanks-1:0]                      narrow_acc;
    logic [NumNarrowBanks-1:0]                      exp_narrow_rvalid;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0] exp_narrow_rdata;
    logic [NumWideBanks-1:0]                        exp_wide_ready;
    logic [NumWideBanks-1:0]                        wide_acc;
    logic [NumWideBanks-1:0]                        exp_wide_rvalid;
    logic [NumWideBanks-1:0][WideDataWidth-1:0]     exp_wide_rdata;
    logic [31:0]                                    lcg_state;

    tb_clk_gen clk_gen0 (.clk_o(clk));

    wide_narrow_mem_top dut0 (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .narrow_valid_i (narrow_valid),
        .narrow_we_i    (narrow_we),
        .narrow_addr_i  (narrow_addr),
        .narrow_wdata_i (narrow_wdata),
        .narrow_strb_i  (narrow_strb),
        .narrow_ready_o (narrow_ready),
        .narrow_rvalid_o(narrow_rvalid),
        .narrow_rdata_o (narrow_rdata),
        .wide_valid_i   (wide_valid),
        .wide_we_i      (wide_we),
        .wide_addr_i    (wide_addr),
        .wide_wdata_i   (wide_wdata),
        .wide_strb_i    (wide_strb),
        .wide_ready_o   (wide_ready),
        .wide_rvalid_o  (wide_rvalid),
        .wide_rdata_o   (wide_rdata)
    );

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] rand32();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] model_word(input int bank, input logic [7:0] row);
        return {ref_mem[bank][row][3], ref_mem[bank][row][2],
                ref_mem[bank][row][1], ref_mem[bank][row][0]};
    endfunction

    // Initial contents depend on bank and row together
    function automatic logic [31:0] fill_word(input logic [2:0] bank, input logic [7:0] row);
        return {row, ~row, 5'h15, bank, row ^ {bank, 5'h0A}};
    endfunction

    // ------------------------------------------------------------------------
    // Prediction of arbitration and responses
    // ------------------------------------------------------------------------
    // Even cycles after release favor narrow ports
    always_comb begin
        for (int j = 0; j < NumWideBanks; j++) begin
            for (int k = 0; k < NarrowPerWide; k++) begin
                exp_narrow_ready[j*NarrowPerWide+k] = cycle_cnt[0] ? ~wide_valid[j] : 1'b1;
            end
            exp_wide_ready[j] = cycle_cnt[0] ? 1'b1
                              : ~(|narrow_valid[j*NarrowPerWide +: NarrowPerWide]);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt         <= '0;
            narrow_acc        <= '0;
            wide_acc          <= '0;
            exp_narrow_rvalid <= '0;
            exp_wide_rvalid   <= '0;
            exp_narrow_rdata  <= '0;
            exp_wide_rdata    <= '0;
        end else begin
            cycle_cnt         <= cycle_cnt + 32'd1;
            narrow_acc        <= narrow_valid & exp_narrow_ready;
            wide_acc          <= wide_valid & exp_wide_ready;
            exp_narrow_rvalid <= narrow_valid & exp_narrow_ready & ~narrow_we;
            exp_wide_rvalid   <= wide_valid & exp_wide_ready & ~wide_we;
            for (int i = 0; i < NumNarrowBanks; i++) begin
                if (narrow_valid[i] && exp_narrow_ready[i]) begin
                    for (int b = 0; b < NarrowStrbWidth; b++) begin
                        if (narrow_we[i] && narrow_strb[i][b]) begin
                            ref_mem[i][narrow_addr[i]][b] <= narrow_wdata[i][b*8 +: 8];
                        end
                    end
                    exp_narrow_rdata[i] <= model_word(i, narrow_addr[i]);
                end
            end
            // Wide lane k of port j lives in bank j*4+k
            for (int j = 0; j < NumWideBanks; j++) begin
                for (int k = 0; k < NarrowPerWide; k++) begin
                    if (wide_valid[j] && exp_wide_ready[j]) begin
                        for (int b = 0; b < NarrowStrbWidth; b++) begin
                            if (wide_we[j] && wide_strb[j][k*4+b]) begin
                                ref_mem[j*NarrowPerWide+k][wide_addr[j]][b] <=
                                    wide_wdata[j][(k*4+b)*8 +: 8];
                            end
                        end
                        exp_wide_rdata[j][k*32 +: 32] <=
                            model_word(j*NarrowPerWide+k, wide_addr[j]);
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------
    a_reset_state: assert property (@(posedge clk) $rose(rst_n) |->
        (narrow_ready == '1 && narrow_rvalid == '0 && wide_rvalid == '0))
        else report_failure($sformatf(
            "ERROR after reset narrow_ready_o %h narrow_rvalid_o %h wide_rvalid_o %h",
            $sampled(narrow_ready), $sampled(narrow_rvalid), $sampled(wide_rvalid)));

    a_narrow_ready: assert property (@(posedge clk) disable iff (!rst_n)
        narrow_ready == exp_narrow_ready)
        else report_failure($sformatf("ERROR narrow_ready_o got %h expected %h",
            $sampled(narrow_ready), $sampled(exp_narrow_ready)));

    a_wide_ready: assert property (@(posedge clk) disable iff (!rst_n)
        wide_ready == exp_wide_ready)
        else report_failure($sformatf("ERROR wide_ready_o got %h expected %h",
            $sampled(wide_ready), $sampled(exp_wide_ready)));

    a_narrow_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        narrow_rvalid == exp_narrow_rvalid)
        else report_failure($sformatf("ERROR narrow_rvalid_o got %h expected %h",
            $sampled(narrow_rvalid), $sampled(exp_narrow_rvalid)));

    a_wide_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        wide_rvalid == exp_wide_rvalid)
        else report_failure($sformatf("ERROR wide_rvalid_o got %h expected %h",
            $sampled(wide_rvalid), $sampled(exp_wide_rvalid)));

    for (genvar i = 0; i < NumNarrowBanks; i++) begin : g_narrow_chk
        a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
            exp_narrow_rvalid[i] |-> narrow_rdata[i] == exp_narrow_rdata[i])
            else report_failure($sformatf("ERROR narrow_rdata_o[%0d] got %h expected %h",
                i, $sampled(narrow_rdata[i]), $sampled(exp_narrow_rdata[i])));
    end

    for (genvar j = 0; j < NumWideBanks; j++) begin : g_wide_chk
        a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
            exp_wide_rvalid[j] |-> wide_rdata[j] == exp_wide_rdata[j])
            else report_failure($sformatf("ERROR wide_rdata_o[%0d] got %h expected %h",
                j, $sampled(wide_rdata[j]), $sampled(exp_wide_rdata[j])));
        // A granted wide port owns its whole group
        a_group: assert property (@(posedge clk) disable iff (!rst_n)
            dut0.bank_wide_sel[j*NarrowPerWide +: NarrowPerWide]
                == {NarrowPerWide{wide_valid[j] & exp_wide_ready[j]}})
            else report_failure($sformatf(
                "ERROR bank_wide_sel group %0d got %h expected %h", j,
                $sampled(dut0.bank_wide_sel[j*NarrowPerWide +: NarrowPerWide]),
                $sampled({NarrowPerWide{wide_valid[j] & exp_wide_ready[j]}})));
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic narrow_access(input logic [2:0] port, input logic we, input logic [7:0] addr,
                                 input logic [31:0] wdata, input logic [3:0] strb);
        int unsigned waited;
        narrow_valid[port] = 1'b1;
        narrow_we[port]    = we;
        narrow_addr[port]  = addr;
        narrow_wdata[port] = wdata;
        narrow_strb[port]  = strb;
        waited = 0;
        step();
        while (!narrow_acc[port] && waited < WaitLimit) begin
            step();
            waited++;
        end
        narrow_valid[port] = 1'b0;
        if (!narrow_acc[port] || (!we && !narrow_rvalid[port])) begin
            report_failure($sformatf("narrow port %0d request or response timed out", port));
        end
    endtask

    task automatic wide_access(input logic port, input logic we, input logic [7:0] addr,
                               input logic [127:0] wdata, input logic [15:0] strb);
        int unsigned waited;
        wide_valid[port] = 1'b1;
        wide_we[port]    = we;
        wide_addr[port]  = addr;
        wide_wdata[port] = wdata;
        wide_strb[port]  = strb;
        waited = 0;
        step();
        while (!wide_acc[port] && waited < WaitLimit) begin
            step();
            waited++;
        end
        wide_valid[port] = 1'b0;
        if (!wide_acc[port] || (!we && !wide_rvalid[port])) begin
            report_failure($sformatf("wide port %0d request or response timed out", port));
        end
    endtask

    // Write every row through both wide ports so no bank holds unknown data
    task automatic preload_rows();
        for (int r = 0; r < BankDepth; r++) begin
            for (int j = 0; j < NumWideBanks; j++) begin
                for (int k = 0; k < NarrowPerWide; k++) begin
                    wide_wdata[1'(j)][k*32 +: 32] = fill_word(3'(j*4+k), 8'(r));
                end
                wide_strb[1'(j)] = '1;
                wide_addr[1'(j)] = 8'(r);
            end
            wide_access(1'b0, 1'b1, 8'(r), wide_wdata[0], 16'hFFFF);
            wide_access(1'b1, 1'b1, 8'(r), wide_wdata[1], 16'hFFFF);
        end
    endtask

    // New request only when the port is idle or was just accepted
    task automatic random_traffic();
        logic [31:0] r;
        for (int c = 0; c < RandomCycles; c++) begin
            for (int i = 0; i < NumNarrowBanks; i++) begin
                if (!narrow_valid[3'(i)] || narrow_acc[3'(i)]) begin
                    r = rand32();
                    narrow_valid[3'(i)] = r[31];
                    narrow_we[3'(i)]    = r[30];
                    narrow_addr[3'(i)]  = r[29:22];
                    narrow_strb[3'(i)]  = r[21:18];
                    narrow_wdata[3'(i)] = rand32();
                end
            end
            for (int j = 0; j < NumWideBanks; j++) begin
                if (!wide_valid[1'(j)] || wide_acc[1'(j)]) begin
                    r = rand32();
                    wide_valid[1'(j)] = r[31];
                    wide_we[1'(j)]    = r[30];
                    wide_addr[1'(j)]  = r[29:22];
                    wide_strb[1'(j)]  = r[21:6];
                    wide_wdata[1'(j)] = {rand32(), rand32(), rand32(), rand32()};
                end
            end
            step();
        end
        narrow_valid = '0;
        wide_valid   = '0;
    endtask

    initial begin
        lcg_state    = 32'h1621;
        rst_n        = 1'b0;
        narrow_valid = '0;
        narrow_we    = '0;
        narrow_addr  = '0;
        narrow_wdata = '0;
        narrow_strb  = '0;
        wide_valid   = '0;
        wide_we      = '0;
        wide_addr    = '0;
        wide_wdata   = '0;
        wide_strb    = '0;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;
        step();
        preload_rows();

        // Partial strobes merge old and new bytes
        narrow_access(3'd3, 1'b1, 8'h10, 32'hDEADBEEF, 4'b0101);
        narrow_access(3'd3, 1'b0, 8'h10, 32'h0, 4'h0);

        // Wide write seen lane by lane, and narrow writes seen by wide reads
        wide_access(1'b1, 1'b1, 8'h20, 128'h0123_4567_89AB_CDEF_FEDC_BA98_7654_3210, 16'hF0F3);
        wide_access(1'b1, 1'b0, 8'h20, '0, '0);
        narrow_access(3'd5, 1'b0, 8'h20, 32'h0, 4'h0);
        narrow_access(3'd6, 1'b1, 8'h21, 32'hCAFEF00D, 4'hF);
        wide_access(1'b1, 1'b0, 8'h21, '0, '0);

        // Held conflict in group 0 where grants follow the phase
        narrow_valid[0] = 1'b1;
        narrow_addr[0]  = 8'h01;
        wide_valid[0]   = 1'b1;
        wide_addr[0]    = 8'h02;
        repeat (12) step();
        narrow_valid = '0;
        wide_valid   = '0;

        random_traffic();
        repeat (4) step();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== bench/tb_clk_gen.sv ====
// Free-running clock source for the scratchpad testbench, 4 ns period
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o
);

    // Half period of 2 ns
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

endmodule

// ==== logic/wide_narrow_mem_top.sv ====
// Top level of the banked scratchpad, eight narrow and two wide ports over eight SRAM banks
`timescale 1ns/1ps

module wide_narrow_mem_top
    import wn_mem_pkg::*;
(
    input  logic                                            clk_i,
    input  logic                                            rst_ni,

    // Narrow ports, one per bank
    input  logic [NumNarrowBanks-1:0]                       narrow_valid_i,
    input  logic [NumNarrowBanks-1:0]                       narrow_we_i,
    input  logic [NumNarrowBanks-1:0][BankAddrWidth-1:0]    narrow_addr_i,
    input  logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  narrow_wdata_i,
    input  logic [NumNarrowBanks-1:0][NarrowStrbWidth-1:0]  narrow_strb_i,
    output logic [NumNarrowBanks-1:0]                       narrow_ready_o,
    output logic [NumNarrowBanks-1:0]                       narrow_rvalid_o,
    output logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0]  narrow_rdata_o,

    // Wide ports, one per group of four banks
    input  logic [NumWideBanks-1:0]                         wide_valid_i,
    input  logic [NumWideBanks-1:0]                         wide_we_i,
    input  logic [NumWideBanks-1:0][BankAddrWidth-1:0]      wide_addr_i,
    input  logic [NumWideBanks-1:0][WideDataWidth-1:0]      wide_wdata_i,
    input  logic [NumWideBanks-1:0][WideStrbWidth-1:0]      wide_strb_i,
    output logic [NumWideBanks-1:0]                         wide_ready_o,
    output logic [NumWideBanks-1:0]                         wide_rvalid_o,
    output logic [NumWideBanks-1:0][WideDataWidth-1:0]      wide_rdata_o
);

    logic [NumNarrowBanks-1:0]                      bank_wide_sel;
    logic [NumNarrowBanks-1:0]                      narrow_req;
    logic [NumWideBanks-1:0]                        wide_req;

    // Bank request and response buses
    logic [NumNarrowBanks-1:0]                      bank_en;
    logic [NumNarrowBanks-1:0]                      bank_we;
    logic [NumNarrowBanks-1:0][BankAddrWidth-1:0]   bank_addr;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0] bank_wdata;
    logic [NumNarrowBanks-1:0][NarrowStrbWidth-1:0] bank_strb;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0] bank_rdata;

    mem_arbiter i_arbiter (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .narrow_valid_i  (narrow_valid_i),
        .wide_valid_i    (wide_valid_i),
        .narrow_ready_o  (narrow_ready_o),
        .wide_ready_o    (wide_ready_o),
        .bank_wide_sel_o (bank_wide_sel)
    );

    // Handshake completes on valid and ready
    assign narrow_req = narrow_valid_i & narrow_ready_o;
    assign wide_req   = wide_valid_i & wide_ready_o;

    // ------------------------------------------------------------------------
    // One steering mux per wide group
    // ------------------------------------------------------------------------
    for (genvar j = 0; j < NumWideBanks; j++) begin : g_group
        bank_port_mux i_mux (
            .clk_i           (clk_i),
            .rst_ni          (rst_ni),
            .bank_wide_sel_i (bank_wide_sel[j*NarrowPerWide +: NarrowPerWide]),
            .narrow_req_i    (narrow_req[j*NarrowPerWide +: NarrowPerWide]),
            .narrow_we_i     (narrow_we_i[j*NarrowPerWide +: NarrowPerWide]),
            .narrow_addr_i   (narrow_addr_i[j*NarrowPerWide +: NarrowPerWide]),
            .narrow_wdata_i  (narrow_wdata_i[j*NarrowPerWide +: NarrowPerWide]),
            .narrow_strb_i   (narrow_strb_i[j*NarrowPerWide +: NarrowPerWide]),
            .wide_req_i      (wide_req[j]),
            .wide_we_i       (wide_we_i[j]),
            .wide_addr_i     (wide_addr_i[j]),
            .wide_wdata_i    (wide_wdata_i[j]),
            .wide_strb_i     (wide_strb_i[j]),
            .bank_rdata_i    (bank_rdata[j*NarrowPerWide +: NarrowPerWide]),
            .bank_en_o       (bank_en[j*NarrowPerWide +: NarrowPerWide]),
            .bank_we_o       (bank_we[j*NarrowPerWide +: NarrowPerWide]),
            .bank_addr_o     (bank_addr[j*NarrowPerWide +: NarrowPerWide]),
            .bank_wdata_o    (bank_wdata[j*NarrowPerWide +: NarrowPerWide]),
            .bank_strb_o     (bank_strb[j*NarrowPerWide +: NarrowPerWide]),
            .narrow_rvalid_o (narrow_rvalid_o[j*NarrowPerWide +: NarrowPerWide]),
            .narrow_rdata_o  (narrow_rdata_o[j*NarrowPerWide +: NarrowPerWide]),
            .wide_rvalid_o   (wide_rvalid_o[j]),
            .wide_rdata_o    (wide_rdata_o[j])
        );
    end

    // ------------------------------------------------------------------------
    // Storage banks
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < NumNarrowBanks; i++) begin : g_bank
        sram_bank i_bank (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .en_i    (bank_en[i]),
            .we_i    (bank_we[i]),
            .addr_i  (bank_addr[i]),
            .wdata_i (bank_wdata[i]),
            .strb_i  (bank_strb[i]),
            .rdata_o (bank_rdata[i])
        );
    end

endmodule

// ==== logic/bank_port_mux.sv ====
// Per-group datapath steering narrow or wide requests into four banks and returning read data
`timescale 1ns/1ps

module bank_port_mux
    import wn_mem_pkg::*;
(
    input  logic                                           clk_i,
    input  logic                                           rst_ni,
    input  logic [NarrowPerWide-1:0]                       bank_wide_sel_i,

    // Accepted narrow requests of this group
    input  logic [NarrowPerWide-1:0]                       narrow_req_i,
    input  logic [NarrowPerWide-1:0]                       narrow_we_i,
    input  logic [NarrowPerWide-1:0][BankAddrWidth-1:0]    narrow_addr_i,
    input  logic [NarrowPerWide-1:0][NarrowDataWidth-1:0]  narrow_wdata_i,
    input  logic [NarrowPerWide-1:0][NarrowStrbWidth-1:0]  narrow_strb_i,

    // Accepted wide request of this group
    input  logic                                           wide_req_i,
    input  logic                                           wide_we_i,
    input  logic [BankAddrWidth-1:0]                       wide_addr_i,
    input  logic [WideDataWidth-1:0]                       wide_wdata_i,
    input  logic [WideStrbWidth-1:0]                       wide_strb_i,

    // Bank side
    input  logic [NarrowPerWide-1:0][NarrowDataWidth-1:0]  bank_rdata_i,
    output logic [NarrowPerWide-1:0]                       bank_en_o,
    output logic [NarrowPerWide-1:0]                       bank_we_o,
    output logic [NarrowPerWide-1:0][BankAddrWidth-1:0]    bank_addr_o,
    output logic [NarrowPerWide-1:0][NarrowDataWidth-1:0]  bank_wdata_o,
    output logic [NarrowPerWide-1:0][NarrowStrbWidth-1:0]  bank_strb_o,

    // Read responses
    output logic [NarrowPerWide-1:0]                       narrow_rvalid_o,
    output logic [NarrowPerWide-1:0][NarrowDataWidth-1:0]  narrow_rdata_o,
    output logic                                           wide_rvalid_o,
    output logic [WideDataWidth-1:0]                       wide_rdata_o
);

    // Per-bank read issued last cycle, and for which side
    logic [NarrowPerWide-1:0] rd_narrow_d, rd_narrow_q;
    logic [NarrowPerWide-1:0] rd_wide_d, rd_wide_q;

    // ------------------------------------------------------------------------
    // Request steering
    // ------------------------------------------------------------------------
    always_comb begin
        for (int k = 0; k < NarrowPerWide; k++) begin
            if (bank_wide_sel_i[k]) begin
                // Lane k of the wide beat, same row in every bank
                bank_en_o[k]    = wide_req_i;
                bank_we_o[k]    = wide_we_i;
                bank_addr_o[k]  = wide_addr_i;
                bank_wdata_o[k] = wide_wdata_i[k*NarrowDataWidth +: NarrowDataWidth];
                bank_strb_o[k]  = wide_strb_i[k*NarrowStrbWidth +: NarrowStrbWidth];
            end else begin
                bank_en_o[k]    = narrow_req_i[k];
                bank_we_o[k]    = narrow_we_i[k];
                bank_addr_o[k]  = narrow_addr_i[k];
                bank_wdata_o[k] = narrow_wdata_i[k];
                bank_strb_o[k]  = narrow_strb_i[k];
            end
        end
    end

    // Reads only, writes give no response
    always_comb begin
        for (int k = 0; k < NarrowPerWide; k++) begin
            rd_wide_d[k]   = bank_wide_sel_i[k] & wide_req_i & ~wide_we_i;
            rd_narrow_d[k] = ~bank_wide_sel_i[k] & narrow_req_i[k] & ~narrow_we_i[k];
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_narrow_q <= '0;
            rd_wide_q   <= '0;
        end else begin
            rd_narrow_q <= rd_narrow_d;
            rd_wide_q   <= rd_wide_d;
        end
    end

    // ------------------------------------------------------------------------
    // Response routing
    // ------------------------------------------------------------------------
    assign narrow_rvalid_o = rd_narrow_q;
    // Wide reads are atomic, so all four flags rise together
    assign wide_rvalid_o   = &rd_wide_q;

    always_comb begin
        for (int k = 0; k < NarrowPerWide; k++) begin
            narrow_rdata_o[k] = rd_narrow_q[k] ? bank_rdata_i[k] : '0;
        end
    end

    // Lane k of the wide response comes from bank k
    always_comb begin
        for (int k = 0; k < NarrowPerWide; k++) begin
            wide_rdata_o[k*NarrowDataWidth +: NarrowDataWidth] =
                wide_rvalid_o ? bank_rdata_i[k] : '0;
        end
    end

endmodule

// ==== logic/mem_arbiter.sv ====
// Narrow/wide conflict arbiter with a toggling priority bit, drives readies and bank ownership
`timescale 1ns/1ps

module mem_arbiter
    import wn_mem_pkg::*;
(
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic [NumNarrowBanks-1:0] narrow_valid_i,
    input  logic [NumWideBanks-1:0]   wide_valid_i,
    output logic [NumNarrowBanks-1:0] narrow_ready_o,
    output logic [NumWideBanks-1:0]   wide_ready_o,
    output logic [NumNarrowBanks-1:0] bank_wide_sel_o
);

    arb_prio_e                 prio_q;
    logic [NumNarrowBanks-1:0] wide_valid_split;
    logic [NumWideBanks-1:0]   narrow_valid_grp;

    // Priority flips every cycle, traffic or not
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= PRIO_NARROW;
        end else begin
            prio_q <= (prio_q == PRIO_NARROW) ? PRIO_WIDE : PRIO_NARROW;
        end
    end

    // ------------------------------------------------------------------------
    // Valid spreading and merging
    // ------------------------------------------------------------------------
    // Each bank sees the valid of the wide port covering it
    always_comb begin
        for (int i = 0; i < NumNarrowBanks; i++) begin
            wide_valid_split[i] = wide_valid_i[i / NarrowPerWide];
        end
    end

    // Any narrow request inside a group blocks the wide port there
    always_comb begin
        for (int j = 0; j < NumWideBanks; j++) begin
            narrow_valid_grp[j] = |narrow_valid_i[j*NarrowPerWide +: NarrowPerWide];
        end
    end

    // ------------------------------------------------------------------------
    // Ready generation
    // ------------------------------------------------------------------------
    always_comb begin
        if (prio_q == PRIO_NARROW) begin
            narrow_ready_o = '1;
            wide_ready_o   = ~narrow_valid_grp;
        end else begin
            wide_ready_o   = '1;
            narrow_ready_o = ~wide_valid_split;
        end
    end

    // Bank goes to the wide side only when its wide port is actually granted,
    // all four banks of the group flip together
    always_comb begin
        for (int i = 0; i < NumNarrowBanks; i++) begin
            bank_wide_sel_o[i] = wide_valid_i[i / NarrowPerWide]
                               & wide_ready_o[i / NarrowPerWide];
        end
    end

endmodule

// ==== logic/sram_bank.sv ====
// Behavioral single-port SRAM bank with byte strobes and a one-cycle registered read
`timescale 1ns/1ps

module sram_bank
    import wn_mem_pkg::*;
(
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic                       en_i,
    input  logic                       we_i,
    input  logic [BankAddrWidth-1:0]   addr_i,
    input  logic [NarrowDataWidth-1:0] wdata_i,
    input  logic [NarrowStrbWidth-1:0] strb_i,
    output logic [NarrowDataWidth-1:0] rdata_o
);

    logic [NarrowDataWidth-1:0] mem_q [BankDepth];
    logic [NarrowDataWidth-1:0] rdata_q;

    // ------------------------------------------------------------------------
    // Storage array
    // ------------------------------------------------------------------------
    // Byte lanes written only where the strobe is set
    always_ff @(posedge clk_i) begin
        if (en_i && we_i) begin
            for (int b = 0; b < NarrowStrbWidth; b++) begin
                if (strb_i[b]) begin
                    mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------
    // Output holds its value between reads
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= '0;
        end else if (en_i && !we_i) begin
            rdata_q <= mem_q[addr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== logic/wn_mem_pkg.sv ====
// Shared sizes and the arbitration priority type, imported by every scratchpad module

package wn_mem_pkg;

    // ------------------------------------------------------------------------
    // Port and bank counts
    // ------------------------------------------------------------------------
    // One bank per narrow port
    localparam int unsigned NumNarrowBanks = 8;
    localparam int unsigned NumWideBanks   = 2;
    // Adjacent banks covered by one wide port
    localparam int unsigned NarrowPerWide  = 4;

    // ------------------------------------------------------------------------
    // Data and strobe widths
    // ------------------------------------------------------------------------
    localparam int unsigned NarrowDataWidth = 32;
    localparam int unsigned WideDataWidth   = 128;
    localparam int unsigned NarrowStrbWidth = NarrowDataWidth / 8;
    localparam int unsigned WideStrbWidth   = WideDataWidth / 8;

    // ------------------------------------------------------------------------
    // Bank geometry
    // ------------------------------------------------------------------------
    localparam int unsigned BankDepth     = 256;
    localparam int unsigned BankAddrWidth = 8;

    // Which side wins this cycle, flips every clock
    typedef enum logic [0:0] {
        PRIO_NARROW = 1'b0,
        PRIO_WIDE   = 1'b1
    } arb_prio_e;

endpackage
